//--- Makefile
SIM      := verilator
TOP      := tb_engine_top
FILELIST := engine_parallel_read_write.f
FLAGS    := --binary --timing --timescale 1ns/1ps --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) graph_engine_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

//--- engine_buffer_memory.sv
// ----------------------------------------------------------
// Local word buffer, one read or write per request
// Emits the packet and its request one cycle later
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module engine_buffer_memory import graph_engine_pkg::*; (
  input  logic             ap_clk,
  input  logic             rst_n,
  engine_stage_if.sink     stage,
  output logic             resp_valid,
  output engine_response_t resp
);

  localparam int DEPTH = 1 << `ENGINE_MEM_DEPTH_LOG2;

  logic [`ENGINE_DATA_W-1:0]        mem [DEPTH];
  logic [DEPTH-1:0]                 written;
  logic [`ENGINE_MEM_DEPTH_LOG2-1:0] addr;
  logic                             accept;

  // Never stalls
  assign stage.ready = 1'b1;
  assign accept      = stage.valid && stage.ready;
  assign addr        = stage.req.address[`ENGINE_MEM_DEPTH_LOG2-1:0];

  // Written flags make unwritten words read as zero
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      written    <= '0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= accept;
      if (accept && stage.req.is_write) written[addr] <= 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept && stage.req.is_write) mem[addr] <= stage.packet.field[0];
    resp.req    <= stage.req;
    resp.packet <= stage.packet;
    // Reads replace field 0 with the stored word
    if (!stage.req.is_write) begin
      resp.packet.field[0]       <= written[addr] ? mem[addr] : '0;
      resp.packet.field_state[0] <= 1'b1;
    end
  end

endmodule

//--- engine_parallel_read_write.f
+incdir+.
graph_engine_pkg.sv
engine_stage_if.sv
engine_skid_queue.sv
engine_rw_control.sv
engine_rw_kernel.sv
engine_buffer_memory.sv
engine_parallel_read_write.sv
tb_clock_gen.sv
tb_engine_checker.sv
tb_engine_top.sv

//--- engine_parallel_read_write.sv
// ----------------------------------------------------------
// Parallel read/write lane top level with plain ports
// Input queue, control, remap kernel, buffer and output queue
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module engine_parallel_read_write import graph_engine_pkg::*; (
  input  logic                                                  ap_clk,
  input  logic                                                  rst_n,
  // Configuration
  input  logic                                                  cfg_load,
  output logic                                                  cfg_ready,
  input  logic [`ENGINE_NUM_FIELDS-1:0]                         cfg_const_mask,
  input  logic [`ENGINE_DATA_W-1:0]                             cfg_const_value,
  input  logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_NUM_FIELDS-1:0] cfg_ops_mask,
  input  logic [`ENGINE_DATA_W-1:0]                             cfg_index_start,
  input  logic [$clog2(`ENGINE_DATA_W)-1:0]                     cfg_granularity,
  input  logic                                                  cfg_direction,
  input  logic                                                  cfg_is_write,
  // Input packets
  input  logic                                                  in_valid,
  output logic                                                  in_ready,
  input  logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_DATA_W-1:0]     in_fields,
  input  logic [`ENGINE_NUM_FIELDS-1:0]                         in_field_state,
  // Responses
  output logic                                                  out_valid,
  input  logic                                                  out_ready,
  output logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_DATA_W-1:0]     out_fields,
  output logic [`ENGINE_NUM_FIELDS-1:0]                         out_field_state,
  output logic [`ENGINE_DATA_W-1:0]                             out_address,
  output logic                                                  out_is_write
);

  engine_config_t   cfg_in, cfg;
  engine_packet_t   in_pkt, q_pkt;
  engine_response_t resp, out_resp;
  logic             q_valid, q_pop, issue, resp_valid;

  engine_stage_if stage ();

  assign cfg_in = '{const_mask: cfg_const_mask, const_value: cfg_const_value,
                    ops_mask: cfg_ops_mask, index_start: cfg_index_start,
                    granularity: cfg_granularity, direction: cfg_direction,
                    is_write: cfg_is_write};
  assign in_pkt = '{field: in_fields, field_state: in_field_state};

  engine_skid_queue #(.payload_t(engine_packet_t)) u_in_queue (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .push_valid(in_valid), .push_ready(in_ready), .push_data(in_pkt),
    .pop_valid(q_valid), .pop_ready(q_pop), .pop_data(q_pkt), .empty());

  engine_rw_control u_control (
    .ap_clk(ap_clk), .rst_n(rst_n), .cfg_load(cfg_load), .cfg_in(cfg_in),
    .cfg_ready(cfg_ready), .q_valid(q_valid), .q_pop(q_pop),
    .out_taken(out_valid && out_ready), .cfg(cfg), .issue(issue));

  engine_rw_kernel u_kernel (
    .ap_clk(ap_clk), .rst_n(rst_n), .cfg(cfg), .issue(issue),
    .packet_in(q_pkt), .stage(stage.source));

  engine_buffer_memory u_memory (
    .ap_clk(ap_clk), .rst_n(rst_n), .stage(stage.sink),
    .resp_valid(resp_valid), .resp(resp));

  // Credits guarantee room, so push_ready is not needed
  engine_skid_queue #(.payload_t(engine_response_t)) u_out_queue (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .push_valid(resp_valid), .push_ready(), .push_data(resp),
    .pop_valid(out_valid), .pop_ready(out_ready), .pop_data(out_resp), .empty());

  assign out_fields      = out_resp.packet.field;
  assign out_field_state = out_resp.packet.field_state;
  assign out_address     = out_resp.req.address;
  assign out_is_write    = out_resp.req.is_write;

endmodule

//--- engine_rw_control.sv
// ----------------------------------------------------------
// Lane control: active configuration, credit count and the
// pop that starts each packet down the kernel pipeline
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module engine_rw_control import graph_engine_pkg::*; (
  input  logic           ap_clk,
  input  logic           rst_n,
  // Configuration load
  input  logic           cfg_load,
  input  engine_config_t cfg_in,
  output logic           cfg_ready,
  // Input queue
  input  logic           q_valid,
  output logic           q_pop,
  // Output queue transfer
  input  logic           out_taken,
  // Kernel
  output engine_config_t cfg,
  output logic           issue
);

  localparam int CREDIT_W = $clog2(`ENGINE_QUEUE_DEPTH + 1);

  logic [CREDIT_W-1:0] credits;

  // A credit covers one item from pop until it leaves the output queue
  assign q_pop = q_valid && (credits < CREDIT_W'(`ENGINE_QUEUE_DEPTH));
  assign issue = q_pop;

  // Idle means nothing in flight and nothing waiting
  assign cfg_ready = (credits == '0) && !q_valid;

  // ----------------------------------------------------------
  // Credit counter
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= '0;
    end else begin
      case ({q_pop, out_taken})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Configuration register
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (cfg_load && cfg_ready) begin
      cfg <= cfg_in;
    end
  end

endmodule

//--- engine_rw_kernel.sv
// ----------------------------------------------------------
// Three-stage field remap and word address computation
// Stage 1 remaps, stage 2 forms the address, stage 3 drives the link
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module engine_rw_kernel import graph_engine_pkg::*; (
  input  logic           ap_clk,
  input  logic           rst_n,
  input  engine_config_t cfg,
  input  logic           issue,
  input  engine_packet_t packet_in,
  engine_stage_if.source stage
);

  // Constant wins, then the highest selected source, else zero and dead
  function automatic engine_packet_t remap(input engine_config_t c,
                                           input engine_packet_t p);
    engine_packet_t r;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      r.field[i]       = '0;
      r.field_state[i] = 1'b0;
      if (c.const_mask[i]) begin
        r.field[i]       = c.const_value;
        r.field_state[i] = 1'b1;
      end else begin
        for (int j = 0; j < `ENGINE_NUM_FIELDS; j++) begin
          if (c.ops_mask[i][j]) begin
            r.field[i]       = p.field[j];
            r.field_state[i] = p.field_state[j];
          end
        end
      end
    end
    return r;
  endfunction

  logic                      valid_s1, valid_s2;
  engine_packet_t            packet_s1, packet_s2;
  logic [`ENGINE_DATA_W-1:0] address_s2;

  // Valid bits travel alongside the payload
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1    <= 1'b0;
      valid_s2    <= 1'b0;
      stage.valid <= 1'b0;
    end else begin
      valid_s1    <= issue;
      valid_s2    <= valid_s1;
      stage.valid <= valid_s2;
    end
  end

  always_ff @(posedge ap_clk) begin
    packet_s1 <= remap(cfg, packet_in);
    // Offset is remapped field 1, which follows the same select rule
    if (cfg.direction) begin
      address_s2 <= (cfg.index_start + packet_s1.field[1]) << cfg.granularity;
    end else begin
      address_s2 <= (cfg.index_start + packet_s1.field[1]) >> cfg.granularity;
    end
    packet_s2          <= packet_s1;
    stage.req.address  <= address_s2;
    stage.req.is_write <= cfg.is_write;
    stage.packet       <= packet_s2;
  end

endmodule

//--- engine_skid_queue.sv
// ----------------------------------------------------------
// Valid/ready circular FIFO, payload type set per instance
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module engine_skid_queue import graph_engine_pkg::*; #(
  parameter type payload_t = engine_packet_t
) (
  input  logic     ap_clk,
  input  logic     rst_n,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data,
  output logic     empty
);

  localparam int DEPTH = `ENGINE_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  payload_t         store [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push, do_pop;

  assign empty      = (count == '0);
  assign pop_valid  = !empty;
  assign push_ready = (count < (PTR_W+1)'(DEPTH));
  assign pop_data   = store[rd_ptr];
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_valid && pop_ready;

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (do_push) store[wr_ptr] <= push_data;
  end

endmodule

//--- engine_stage_if.sv
// ----------------------------------------------------------
// Link from the remap kernel to the buffer memory
// ----------------------------------------------------------

interface engine_stage_if import graph_engine_pkg::*; ();

  logic            valid;
  logic            ready;
  engine_request_t req;
  engine_packet_t  packet;

  // Kernel side
  modport source (
    output valid, req, packet,
    input  ready
  );

  // Memory side
  modport sink (
    input  valid, req, packet,
    output ready
  );

endinterface

//--- graph_engine_pkg.sv
// ----------------------------------------------------------
// Shared types of the graph engine lane
// Modules take them with a wildcard import
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

package graph_engine_pkg;

  // ----------------------------------------------------------
  // Packet
  // ----------------------------------------------------------
  // One state bit per field, high when the field holds live data
  typedef struct packed {
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_DATA_W-1:0] field;
    logic [`ENGINE_NUM_FIELDS-1:0]                     field_state;
  } engine_packet_t;

  // ----------------------------------------------------------
  // Lane configuration
  // ----------------------------------------------------------
  // ops_mask[i] selects the source fields of output field i
  typedef struct packed {
    logic [`ENGINE_NUM_FIELDS-1:0]                         const_mask;
    logic [`ENGINE_DATA_W-1:0]                             const_value;
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_NUM_FIELDS-1:0] ops_mask;
    logic [`ENGINE_DATA_W-1:0]                             index_start;
    logic [$clog2(`ENGINE_DATA_W)-1:0]                     granularity;
    logic                                                  direction;  // 1 shifts left
    logic                                                  is_write;
  } engine_config_t;

  // ----------------------------------------------------------
  // Memory request and response
  // ----------------------------------------------------------
  typedef struct packed {
    logic [`ENGINE_DATA_W-1:0] address;
    logic                      is_write;
  } engine_request_t;

  typedef struct packed {
    engine_packet_t  packet;
    engine_request_t req;
  } engine_response_t;

endpackage

//--- graph_engine_settings.svh
// ----------------------------------------------------------
// Sizing macros for the graph engine read/write lane
// Include this file wherever field, memory or queue sizes are needed
// ----------------------------------------------------------

`ifndef GRAPH_ENGINE_SETTINGS_SVH
`define GRAPH_ENGINE_SETTINGS_SVH

// Packet layout
`define ENGINE_NUM_FIELDS 4
`define ENGINE_DATA_W 32

// 256-word local buffer, indexed by the low address bits
`define ENGINE_MEM_DEPTH_LOG2 8

// Entries per queue, also the credit limit of the lane
`define ENGINE_QUEUE_DEPTH 8

`endif

//--- tb_clock_gen.sv
// ----------------------------------------------------------
// Testbench clock and reset, reset held low for two cycles
// ----------------------------------------------------------

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic ap_clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    ap_clk = 1'b0;
    forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    rst_n <= 1'b1;
  end

endmodule

//--- tb_engine_checker.sv
// ----------------------------------------------------------
// Watches the lane ports, models configuration, remap and buffer
// and compares every response taken from the output
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module tb_engine_checker #(
  parameter int LATENCY = 6
) (
  input  logic                                                  ap_clk,
  input  logic                                                  rst_n,
  input  logic                                                  cfg_load,
  input  logic                                                  cfg_ready,
  input  logic [`ENGINE_NUM_FIELDS-1:0]                         cfg_const_mask,
  input  logic [`ENGINE_DATA_W-1:0]                             cfg_const_value,
  input  logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_NUM_FIELDS-1:0] cfg_ops_mask,
  input  logic [`ENGINE_DATA_W-1:0]                             cfg_index_start,
  input  logic [$clog2(`ENGINE_DATA_W)-1:0]                     cfg_granularity,
  input  logic                                                  cfg_direction,
  input  logic                                                  cfg_is_write,
  input  logic                                                  in_valid,
  input  logic                                                  in_ready,
  input  logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_DATA_W-1:0]     in_fields,
  input  logic [`ENGINE_NUM_FIELDS-1:0]                         in_field_state,
  input  logic                                                  out_valid,
  input  logic                                                  out_ready,
  input  logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_DATA_W-1:0]     out_fields,
  input  logic [`ENGINE_NUM_FIELDS-1:0]                         out_field_state,
  input  logic [`ENGINE_DATA_W-1:0]                             out_address,
  input  logic                                                  out_is_write,
  // Test sequencing from the top
  input  logic                                                  test_done,
  input  int                                                    test_num,
  input  logic                                                  check_latency,
  input  logic                                                  hold_out,
  input  logic                                                  want_full,
  output int                                                    errors,
  output int                                                    outputs,
  output int                                                    tests
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NF = `ENGINE_NUM_FIELDS;
  localparam int DW = `ENGINE_DATA_W;
  localparam int MW = `ENGINE_MEM_DEPTH_LOG2;

  typedef struct packed {
    logic [NF-1:0][DW-1:0] fields;
    logic [NF-1:0]         state;
    logic [DW-1:0]         address;
    logic                  is_write;
  } expect_t;

  // Model copy of the active configuration
  logic [NF-1:0]         m_const_mask = '0;
  logic [DW-1:0]         m_const_value = '0;
  logic [NF-1:0][NF-1:0] m_ops_mask = '0;
  logic [DW-1:0]         m_index_start = '0;
  logic [$clog2(DW)-1:0] m_granularity = '0;
  logic                  m_direction = 1'b0;
  logic                  m_is_write = 1'b0;

  logic [DW-1:0] mem_model [1 << MW];
  expect_t       exp_q [$];
  int            exp_cycle [$];
  expect_t       e;
  int            cycle = 0;
  int            in_cycle;
  int            test_errors = 0;
  int            test_outputs = 0;
  logic          full_seen = 1'b0;

  initial begin
    errors  = 0;
    outputs = 0;
    tests   = 0;
    for (int a = 0; a < (1 << MW); a++) mem_model[a] = '0;
  end

  // Constant first, then the highest selected source, else zero and dead
  function automatic expect_t model_packet(input logic [NF-1:0][DW-1:0] f,
                                           input logic [NF-1:0] s);
    expect_t       r;
    logic          found;
    logic [DW-1:0] sum;
    r = '0;
    for (int i = 0; i < NF; i++) begin
      found = 1'b0;
      if (m_const_mask[i]) begin
        r.fields[i] = m_const_value;
        r.state[i]  = 1'b1;
      end else begin
        for (int j = NF - 1; j >= 0; j--) begin
          if (!found && m_ops_mask[i][j]) begin
            r.fields[i] = f[j];
            r.state[i]  = s[j];
            found       = 1'b1;
          end
        end
      end
    end
    // Offset is output field 1
    sum        = m_index_start + r.fields[1];
    r.address  = m_direction ? (sum << m_granularity) : (sum >> m_granularity);
    r.is_write = m_is_write;
    return r;
  endfunction

  task automatic count_failure();
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
    if (expected !== actual) begin
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
      count_failure();
    end
  endtask

  always @(posedge ap_clk) begin
    if (rst_n) begin
      // Idle exactly when nothing is in flight
      check_value("cfg_ready", DW'(exp_q.size() == 0), DW'(cfg_ready));
      if (out_valid && out_ready) begin
        outputs++;
        test_outputs++;
        if (exp_q.size() == 0) begin
          $display("Output at %0t arrived with no matching input packet", $time);
          count_failure();
        end else begin
          e        = exp_q.pop_front();
          in_cycle = exp_cycle.pop_front();
          for (int i = 0; i < NF; i++) begin
            check_value($sformatf("out_fields[%0d]", i), e.fields[i], out_fields[i]);
          end
          check_value("out_field_state", DW'(e.state), DW'(out_field_state));
          check_value("out_address", e.address, out_address);
          check_value("out_is_write", DW'(e.is_write), DW'(out_is_write));
          if (check_latency) begin
            check_value("output latency", DW'(LATENCY), DW'(cycle - in_cycle));
          end
        end
      end
      if (in_valid && in_ready) begin
        e = model_packet(in_fields, in_field_state);
        if (e.is_write) begin
          mem_model[e.address[MW-1:0]] = e.fields[0];
        end else begin
          e.fields[0] = mem_model[e.address[MW-1:0]];
          e.state[0]  = 1'b1;
        end
        exp_q.push_back(e);
        exp_cycle.push_back(cycle);
      end
      if (cfg_load && cfg_ready) begin
        m_const_mask  = cfg_const_mask;
        m_const_value = cfg_const_value;
        m_ops_mask    = cfg_ops_mask;
        m_index_start = cfg_index_start;
        m_granularity = cfg_granularity;
        m_direction   = cfg_direction;
        m_is_write    = cfg_is_write;
      end
      if (hold_out && !in_ready) full_seen = 1'b1;
      if (test_done) begin
        if (exp_q.size() != 0) begin
          $display("Test %0d ended with %0d packets never returned", test_num, exp_q.size());
          count_failure();
        end
        if (want_full && !full_seen) begin
          $display("Test %0d: in_ready never fell while out_ready was held low", test_num);
          count_failure();
        end
        $display("Test %0d done: %0d outputs, %0d errors", test_num, test_outputs,
                 test_errors);
        tests++;
        test_outputs = 0;
        test_errors  = 0;
        full_seen    = 1'b0;
      end
      cycle++;
    end
  end

endmodule

//--- tb_engine_top.sv
// ----------------------------------------------------------
// Testbench top for the parallel read/write lane
// Random packets per configuration phase, checked by the checker
// ----------------------------------------------------------

`include "graph_engine_settings.svh"

module tb_engine_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NF          = `ENGINE_NUM_FIELDS;
  localparam int DW          = `ENGINE_DATA_W;
  localparam int NUM_TESTS   = 5;
  localparam int NUM_PACKETS = 200;
  localparam int WATCHDOG_NS = NUM_TESTS * NUM_PACKETS * 20 * 8;

  logic                  ap_clk, rst_n;
  logic                  cfg_load, cfg_ready, cfg_direction, cfg_is_write;
  logic [NF-1:0]         cfg_const_mask;
  logic [DW-1:0]         cfg_const_value, cfg_index_start;
  logic [NF-1:0][NF-1:0] cfg_ops_mask;
  logic [$clog2(DW)-1:0] cfg_granularity;
  logic                  in_valid, in_ready, out_valid, out_ready, out_is_write;
  logic [NF-1:0][DW-1:0] in_fields, out_fields;
  logic [NF-1:0]         in_field_state, out_field_state;
  logic [DW-1:0]         out_address;
  logic                  test_done, check_latency, hold_out, want_full;
  int                    test_num, errors, outputs, tests;
  bit                    holding;

  tb_clock_gen u_clock (.ap_clk(ap_clk), .rst_n(rst_n));

  engine_parallel_read_write UUT (.*);

  tb_engine_checker u_checker (.*);

  // Mode 0 random out_ready, 1 always ready, 2 held low until in_ready falls
  task automatic set_out_ready(input int mode);
    case (mode)
      1:       out_ready <= 1'b1;
      2:       out_ready <= holding ? 1'b0 : 1'($urandom);
      default: out_ready <= 1'($urandom);
    endcase
  endtask

  task automatic drive_packets(input int mode);
    int sent;
    bit accepted;
    sent    = 0;
    holding = (mode == 2);
    hold_out <= holding;
    while (sent < NUM_PACKETS) begin
      if ($urandom_range(3) != 0) begin
        in_valid       <= 1'b1;
        in_fields      <= {$urandom, $urandom, $urandom, $urandom};
        in_field_state <= 4'($urandom);
        accepted = 1'b0;
        while (!accepted) begin
          set_out_ready(mode);
          @(posedge ap_clk);
          accepted = in_ready;
          if (holding && !in_ready) begin
            holding = 1'b0;
            hold_out <= 1'b0;
          end
        end
        sent++;
        in_valid <= 1'b0;
      end else begin
        set_out_ready(mode);
        @(posedge ap_clk);
      end
    end
  endtask

  task automatic run_test(input int t);
    int mode;
    mode = (t == 3) ? 2 : ((t == 4) ? 1 : 0);
    // Test 2 reads back with the write configuration of test 1
    if (t != 2) begin
      cfg_const_mask  <= 4'($urandom);
      cfg_const_value <= $urandom;
      cfg_ops_mask    <= 16'($urandom);
      cfg_index_start <= $urandom;
      cfg_granularity <= 5'($urandom);
      cfg_direction   <= (t == 0);
      cfg_is_write    <= (t == 1);
    end
    if (t == 0) begin
      // Field 2 always takes the constant and field 3 has no source
      cfg_const_mask[3:2] <= 2'b01;
      cfg_ops_mask[3]     <= '0;
    end
    if (t == 1) begin
      cfg_const_mask[1:0] <= 2'b00;
      cfg_ops_mask[1]     <= 4'($urandom_range(15, 1));
      cfg_granularity     <= '0;
    end
    if (t == 2) cfg_is_write <= 1'b0;
    check_latency <= (mode == 1);
    want_full     <= (mode == 2);
    cfg_load      <= 1'b1;
    @(posedge ap_clk);
    while (!cfg_ready) @(posedge ap_clk);
    cfg_load <= 1'b0;
    drive_packets(mode);
    // Drain everything still in flight
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    hold_out  <= 1'b0;
    @(posedge ap_clk);
    while (!cfg_ready) @(posedge ap_clk);
    test_num  <= t;
    test_done <= 1'b1;
    @(posedge ap_clk);
    test_done <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h5720));
    cfg_load        = 1'b0;
    cfg_const_mask  = '0;
    cfg_const_value = '0;
    cfg_ops_mask    = '0;
    cfg_index_start = '0;
    cfg_granularity = '0;
    cfg_direction   = 1'b0;
    cfg_is_write    = 1'b0;
    in_valid        = 1'b0;
    in_fields       = '0;
    in_field_state  = '0;
    out_ready       = 1'b1;
    test_done       = 1'b0;
    test_num        = 0;
    check_latency   = 1'b0;
    hold_out        = 1'b0;
    want_full       = 1'b0;
    wait (rst_n === 1'b1);
    @(posedge ap_clk);
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    @(posedge ap_clk);
    $display("Summary: %0d tests, %0d outputs, %0d errors", tests, outputs, errors);
    if (errors == 0 && tests == NUM_TESTS) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Run hung: the watchdog expired before all tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule
